/* clut_paint.sv */
// ------------------------------
// palette lookup, paint masking
// and the registered output
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module clut_paint import fb_display_pkg::*; #(
    parameter int FB_WIDTH  = 16,
    parameter int FB_HEIGHT = 12,
    parameter int FB_SCALE  = 2
) (
    input  wire logic             clk_sys,
    input  wire logic             rst_n,
    pix_stream_if.sink            pix,
    output logic      [CORDW-1:0] out_sx,
    output logic      [CORDW-1:0] out_sy,
    output logic                  out_de,
    output logic                  out_frame,
    output logic      [OUTW-1:0]  out_r,
    output logic      [OUTW-1:0]  out_g,
    output logic      [OUTW-1:0]  out_b
);

    localparam int PAINT_W = FB_WIDTH * FB_SCALE;   // scaled image width
    localparam int PAINT_H = FB_HEIGHT * FB_SCALE;
    localparam int WIDEN   = OUTW / CHANW;          // nibble repeats

    logic [COLRW-1:0] colr_q;  // palette colour, stage 1
    logic [CORDW-1:0] sx_q, sy_q;
    logic             de_q, frame_q;
    logic             paint;   // inside scaled image and visible
    logic [CHANW-1:0] paint_r, paint_g, paint_b;

    // stage 1, palette lookup
    always_ff @(posedge clk_sys) begin
        colr_q <= palette_grey(pix.cidx);
        sx_q   <= pix.sx;
        sy_q   <= pix.sy;
        if (!rst_n) begin
            de_q    <= 1'b0;
            frame_q <= 1'b0;
        end else begin
            de_q    <= pix.de;
            frame_q <= pix.frame;
        end
    end

    always_comb begin
        paint = de_q && (sx_q < CORDW'(PAINT_W)) && (sy_q < CORDW'(PAINT_H));
        {paint_r, paint_g, paint_b} = paint ? colr_q : '0;  // black elsewhere
    end

    // stage 2, output register
    always_ff @(posedge clk_sys) begin
        out_sx <= sx_q;
        out_sy <= sy_q;
        if (!rst_n) begin
            out_de    <= 1'b0;
            out_frame <= 1'b0;
            out_r     <= '0;
            out_g     <= '0;
            out_b     <= '0;
        end else begin
            out_de    <= de_q;
            out_frame <= frame_q;
            out_r     <= {WIDEN{paint_r}};  // 4'ha becomes 8'haa
            out_g     <= {WIDEN{paint_g}};
            out_b     <= {WIDEN{paint_b}};
        end
    end

endmodule

`default_nettype wire

/* display_timing.sv */
// ------------------------------
// screen position counters
// plus frame and line pulses
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module display_timing import fb_display_pkg::*; (
    input  wire logic             clk_sys,
    input  wire logic             rst_n,
    output logic      [CORDW-1:0] sx,     // horizontal position
    output logic      [CORDW-1:0] sy,     // vertical position
    output logic                  de,     // high in visible area
    output logic                  frame,  // one cycle at (0,0)
    output logic                  line    // one cycle at sx 0
);

    localparam logic [CORDW-1:0] H_LAST = CORDW'(H_TOTAL - 1);
    localparam logic [CORDW-1:0] V_LAST = CORDW'(V_TOTAL - 1);

    logic h_end;  // last pixel of line
    logic v_end;  // last line of frame

    always_comb begin
        h_end = (sx == H_LAST);
        v_end = (sy == V_LAST);
    end

    // position counters, wrap at the totals
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (h_end) begin
            sx <= '0;
            sy <= v_end ? '0 : sy + 1'b1;  // next line or back to top
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // flags decoded straight from the count registers
    always_comb begin
        de    = (sx < CORDW'(H_ACTIVE)) && (sy < CORDW'(V_ACTIVE));
        line  = (sx == '0);
        frame = (sx == '0) && (sy == '0);
    end

endmodule

`default_nettype wire

/* fb_display_assert.sv */
// ------------------------------
// concurrent checks on the outputs
// of the display top level
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module fb_display_assert import fb_display_pkg::*; (
    input wire logic            clk_sys,
    input wire logic            rst_n,
    input wire logic            out_de,
    input wire logic            out_frame,
    input wire logic [OUTW-1:0] out_r,
    input wire logic [OUTW-1:0] out_g,
    input wire logic [OUTW-1:0] out_b
);

    // flags low one cycle into reset
    reset_clears_flags: assert property (
        @(posedge clk_sys) !rst_n |=> (!out_de && !out_frame)
    ) else $error("out_de or out_frame still high after reset");

    // grey palette, so all channels match
    grey_channels_equal: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (out_r == out_g) && (out_g == out_b)
    ) else $error("colour channels differ: r %0h g %0h b %0h", out_r, out_g, out_b);

    // blanking is always black
    blank_is_black: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !out_de |-> (out_r == '0) && (out_g == '0) && (out_b == '0)
    ) else $error("non-zero colour while out_de is low");

endmodule

// attach to every instance of the top level
bind fb_display_top fb_display_assert fb_display_assert_i (
    .clk_sys, .rst_n,
    .out_de, .out_frame,
    .out_r, .out_g, .out_b
);

`default_nettype wire

/* fb_display_pkg.sv */
// ------------------------------
// screen timing constants, widths
// and the fixed grey palette
// ------------------------------
`default_nettype none

package fb_display_pkg;

    // coordinate width, unsigned
    localparam int CORDW = 16;

    // horizontal timing in pixels
    localparam int H_ACTIVE = 40;  // visible
    localparam int H_TOTAL  = 52;  // incl blanking

    // vertical timing in lines
    localparam int V_ACTIVE = 30;
    localparam int V_TOTAL  = 34;

    // colour widths
    localparam int CIDXW = 4;          // colour index
    localparam int CHANW = 4;          // palette channel
    localparam int COLRW = 3 * CHANW;  // r, g, b packed
    localparam int OUTW  = 8;          // output channel

    // grey ramp, every channel follows the index
    function automatic logic [COLRW-1:0] palette_grey(input logic [CIDXW-1:0] idx);
        logic [CHANW-1:0] chan;
        chan = CHANW'(idx);
        palette_grey = {chan, chan, chan};  // r in top bits
    endfunction

endpackage

`default_nettype wire

/* fb_display_top.sv */
// ------------------------------
// scaled framebuffer display top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module fb_display_top import fb_display_pkg::*; #(
    parameter int FB_WIDTH  = 16,  // framebuffer columns
    parameter int FB_HEIGHT = 12,  // framebuffer rows
    parameter int FB_SCALE  = 2    // pixel repeat both ways
) (
    input  wire logic             clk_sys,
    input  wire logic             rst_n,
    input  wire logic             fb_we,      // framebuffer write strobe
    input  wire logic [CORDW-1:0] fb_x,
    input  wire logic [CORDW-1:0] fb_y,
    input  wire logic [CIDXW-1:0] fb_idx,
    output logic      [CORDW-1:0] out_sx,     // 3 cycles behind timing
    output logic      [CORDW-1:0] out_sy,
    output logic                  out_de,
    output logic                  out_frame,
    output logic      [OUTW-1:0]  out_r,
    output logic      [OUTW-1:0]  out_g,
    output logic      [OUTW-1:0]  out_b
);

    localparam int FB_ADDRW = $clog2(FB_WIDTH * FB_HEIGHT);

    logic [CORDW-1:0]    sx, sy;
    logic                de, frame, line;
    logic [FB_ADDRW-1:0] fb_rd_addr;
    logic [CIDXW-1:0]    fb_rd_idx;

    pix_stream_if pix_s ();  // line_scaler to clut_paint

    display_timing display_timing_i (
        .clk_sys, .rst_n,
        .sx, .sy, .de, .frame, .line
    );

    framebuffer_mem #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)
    ) framebuffer_mem_i (
        .clk_sys,
        .we(fb_we), .wr_x(fb_x), .wr_y(fb_y), .wr_idx(fb_idx),
        .rd_addr(fb_rd_addr), .rd_idx(fb_rd_idx)
    );

    line_scaler #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE)
    ) line_scaler_i (
        .clk_sys, .rst_n,
        .sx, .sy, .de, .frame, .line,
        .rd_addr(fb_rd_addr), .rd_idx(fb_rd_idx),
        .pix(pix_s.source)
    );

    clut_paint #(
        .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT), .FB_SCALE(FB_SCALE)
    ) clut_paint_i (
        .clk_sys, .rst_n,
        .pix(pix_s.sink),
        .out_sx, .out_sy, .out_de, .out_frame,
        .out_r, .out_g, .out_b
    );

endmodule

`default_nettype wire

/* fb_stimulus.txt */
# each image: a header line, then 12 rows of the framebuffer
# each row: 16 hex colour indices, column 0 first
image 1
0123456789abcdef
123456789abcdef0
23456789abcdef01
3456789abcdef012
456789abcdef0123
56789abcdef01234
6789abcdef012345
789abcdef0123456
89abcdef01234567
9abcdef012345678
abcdef0123456789
bcdef0123456789a
image 2
fedcba9876543210
edcba9876543210f
dcba9876543210fe
cba9876543210fed
ba9876543210fedc
a9876543210fedcb
9876543210fedcba
876543210fedcba9
76543210fedcba98
6543210fedcba987
543210fedcba9876
43210fedcba98765

/* filelist.f */
fb_display_pkg.sv
pix_stream_if.sv
display_timing.sv
framebuffer_mem.sv
line_scaler.sv
clut_paint.sv
fb_display_top.sv
fb_display_assert.sv
tb_fb_display.sv

/* framebuffer_mem.sv */
// ------------------------------
// framebuffer of colour indices
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module framebuffer_mem import fb_display_pkg::*; #(
    parameter  int FB_WIDTH  = 16,
    parameter  int FB_HEIGHT = 12,
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT,
    localparam int FB_ADDRW  = $clog2(FB_PIXELS)
) (
    input  wire logic                clk_sys,
    input  wire logic                we,       // write strobe
    input  wire logic [CORDW-1:0]    wr_x,     // column to write
    input  wire logic [CORDW-1:0]    wr_y,     // row to write
    input  wire logic [CIDXW-1:0]    wr_idx,   // new colour index
    input  wire logic [FB_ADDRW-1:0] rd_addr,  // linear read address
    output logic      [CIDXW-1:0]    rd_idx    // one cycle after rd_addr
);

    // power-up contents all index 0
    logic [CIDXW-1:0] mem [FB_PIXELS] = '{default: '0};

    logic                wr_ok;    // target inside the buffer
    logic [FB_ADDRW-1:0] wr_addr;

    always_comb begin
        wr_ok   = (wr_x < CORDW'(FB_WIDTH)) && (wr_y < CORDW'(FB_HEIGHT));
        wr_addr = FB_ADDRW'(wr_y * FB_WIDTH + wr_x);  // row major
    end

    always_ff @(posedge clk_sys) begin
        if (we && wr_ok) begin
            mem[wr_addr] <= wr_idx;  // out of range writes dropped
        end
        rd_idx <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* line_scaler.sv */
// ------------------------------
// row fetch to ping-pong buffer
// and pixel repetition
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module line_scaler import fb_display_pkg::*; #(
    parameter  int FB_WIDTH  = 16,
    parameter  int FB_HEIGHT = 12,
    parameter  int FB_SCALE  = 2,
    localparam int FB_ADDRW  = $clog2(FB_WIDTH * FB_HEIGHT)
) (
    input  wire logic                clk_sys,
    input  wire logic                rst_n,
    input  wire logic [CORDW-1:0]    sx,
    input  wire logic [CORDW-1:0]    sy,
    input  wire logic                de,
    input  wire logic                frame,
    input  wire logic                line,
    output logic      [FB_ADDRW-1:0] rd_addr,  // framebuffer read address
    input  wire logic [CIDXW-1:0]    rd_idx,   // framebuffer read data
    pix_stream_if.source             pix
);

    localparam int XW = (FB_WIDTH > 1) ? $clog2(FB_WIDTH) : 1;  // buffer column
    localparam int SW = (FB_SCALE > 1) ? $clog2(FB_SCALE) : 1;  // repeat count

    logic [CIDXW-1:0] lb_mem [2][FB_WIDTH] = '{default: '0};  // two line buffers

    logic [SW-1:0]    vsub_q, vsub_nx;  // line within a scaled row
    logic [CORDW-1:0] vrow_q, vrow_nx;  // framebuffer row of the line
    logic             fetch_go;         // start fetching for next line
    logic             fetch_act, wr_act;
    logic [XW-1:0]    fetch_cnt, wr_col;
    logic             fetch_buf;        // buffer being filled
    logic             front_sel;        // buffer on display
    logic             swap_pend;        // filled buffer waits for next line
    logic             rd_sel;
    logic [XW-1:0]    hcol_q, hcol;     // displayed buffer column
    logic [SW-1:0]    hsub_q, hsub;

    // row and sub-row of the next line, sy+1 wrapping to 0
    always_comb begin
        if (sy == CORDW'(V_TOTAL - 1)) begin
            vsub_nx = '0;
            vrow_nx = '0;
        end else if (vsub_q == SW'(FB_SCALE - 1)) begin
            vsub_nx = '0;
            vrow_nx = vrow_q + 1'b1;
        end else begin
            vsub_nx = vsub_q + 1'b1;
            vrow_nx = vrow_q;
        end
        fetch_go = line && (vsub_nx == '0) && (vrow_nx < CORDW'(FB_HEIGHT));
        rd_sel   = (line && swap_pend) ? ~front_sel : front_sel;  // swap at line start
        hcol     = line ? '0 : hcol_q;
        hsub     = line ? '0 : hsub_q;
    end

    // control state
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            vsub_q    <= '0;
            vrow_q    <= '0;
            fetch_act <= 1'b0;
            wr_act    <= 1'b0;
            front_sel <= 1'b0;
            swap_pend <= 1'b0;
            hcol_q    <= '0;
            hsub_q    <= '0;
        end else begin
            wr_act <= fetch_act;  // data returns a cycle later
            if (line) begin
                vsub_q    <= vsub_nx;
                vrow_q    <= vrow_nx;
                front_sel <= rd_sel;
                swap_pend <= fetch_go;
            end
            if (fetch_go) begin
                fetch_act <= 1'b1;
            end else if (fetch_act && fetch_cnt == XW'(FB_WIDTH - 1)) begin
                fetch_act <= 1'b0;  // whole row requested
            end
            // divide counter for sx / FB_SCALE, held at the last column
            if (hsub == SW'(FB_SCALE - 1)) begin
                hsub_q <= '0;
                hcol_q <= (hcol == XW'(FB_WIDTH - 1)) ? hcol : hcol + 1'b1;
            end else begin
                hsub_q <= hsub + 1'b1;
                hcol_q <= hcol;
            end
        end
    end

    // fetch address and buffer fill
    always_ff @(posedge clk_sys) begin
        wr_col <= fetch_cnt;
        if (fetch_go) begin
            fetch_cnt <= '0;
            fetch_buf <= ~rd_sel;  // the one not shown next line
            rd_addr   <= FB_ADDRW'(vrow_nx * FB_WIDTH);
        end else if (fetch_act) begin
            fetch_cnt <= fetch_cnt + 1'b1;
            rd_addr   <= rd_addr + 1'b1;
        end
        if (wr_act) begin
            lb_mem[fetch_buf][wr_col] <= rd_idx;
        end
    end

    // front buffer read, coordinates delayed to match
    always_ff @(posedge clk_sys) begin
        pix.cidx <= lb_mem[rd_sel][hcol];
        pix.sx   <= sx;
        pix.sy   <= sy;
        if (!rst_n) begin
            pix.de    <= 1'b0;
            pix.frame <= 1'b0;
        end else begin
            pix.de    <= de;
            pix.frame <= frame;
        end
    end

endmodule

`default_nettype wire

/* pix_stream_if.sv */
// ------------------------------
// pixel stream between stages
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface pix_stream_if import fb_display_pkg::*; ();

    logic [CORDW-1:0] sx;     // screen x of this pixel
    logic [CORDW-1:0] sy;     // screen y
    logic             de;     // visible region
    logic             frame;  // first pixel of frame
    logic [CIDXW-1:0] cidx;   // colour index from line buffer

    // stage that produces the pixel
    modport source (
        output sx, sy, de, frame, cidx
    );

    // stage that consumes it
    modport sink (
        input sx, sy, de, frame, cidx
    );

endinterface

`default_nettype wire

/* tb_fb_display.sv */
// ------------------------------
// framebuffer display testbench
// image loading and whole frame checks
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_fb_display import fb_display_pkg::*; ();

    localparam int FB_W       = 16;
    localparam int FB_H       = 12;
    localparam int FB_S       = 2;
    localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;
    localparam int MAX_GAP    = 3;                             // max idle cycles in image 2
    localparam int WRITE_CYC  = FB_W * FB_H * (4 + MAX_GAP) + 16;  // both images
    localparam int CLK_NS     = 20;
    localparam int TIMEOUT_NS = (6 * FRAME_CYC + WRITE_CYC) * CLK_NS;

    logic             clk_sys = 1'b0;
    logic             rst_n;
    logic             fb_we;
    logic [CORDW-1:0] fb_x;
    logic [CORDW-1:0] fb_y;
    logic [CIDXW-1:0] fb_idx;
    logic [CORDW-1:0] out_sx;
    logic [CORDW-1:0] out_sy;
    logic             out_de;
    logic             out_frame;
    logic [OUTW-1:0]  out_r;
    logic [OUTW-1:0]  out_g;
    logic [OUTW-1:0]  out_b;

    logic [CIDXW-1:0] img_data [2][FB_H][FB_W];  // both images from the file

    fb_display_top #(
        .FB_WIDTH(FB_W), .FB_HEIGHT(FB_H), .FB_SCALE(FB_S)
    ) fb_display_top_i (
        .clk_sys, .rst_n,
        .fb_we, .fb_x, .fb_y, .fb_idx,
        .out_sx, .out_sy, .out_de, .out_frame,
        .out_r, .out_g, .out_b
    );

    always #(CLK_NS / 2) clk_sys = ~clk_sys;  // 50 MHz

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            abort_run("output mismatch");
        end
    endtask

    // image header line then 12 rows of 16 hex digits
    task automatic load_images();
        int                fd;
        int                img;
        int                row;
        string             line;
        logic [4*FB_W-1:0] bits;
        img = -1;
        row = 0;
        fd  = $fopen("fb_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the stimulus file fb_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() >= 2 && line.getc(0) != "#") begin  // skip comments and blanks
                    if (line.substr(0, 4) == "image") begin
                        img++;
                        row = 0;
                    end else if (img < 0 || img > 1 || row >= FB_H
                                 || $sscanf(line, "%h", bits) != 1) begin
                        abort_run("malformed line in the stimulus file");
                    end else begin
                        // column 0 in the top nibble
                        for (int x = 0; x < FB_W; x++) begin
                            img_data[img][row][x] = bits[4*(FB_W-1-x) +: 4];
                        end
                        row++;
                    end
                end
            end
            $fclose(fd);
            if (img != 1 || row != FB_H) begin
                abort_run("stimulus file does not hold two full images");
            end
        end
    endtask

    task automatic write_pixel(input int x, input int y, input logic [CIDXW-1:0] idx);
        @(posedge clk_sys);
        fb_we  <= 1'b1;
        fb_x   <= CORDW'(x);
        fb_y   <= CORDW'(y);
        fb_idx <= idx;
        @(posedge clk_sys);
        fb_we  <= 1'b0;  // one-cycle strobe
    endtask

    task automatic write_image(input int img, input bit gaps);
        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                write_pixel(x, y, img_data[img][y][x]);
                if (gaps) begin
                    repeat ($urandom_range(MAX_GAP, 0)) @(posedge clk_sys);
                end
            end
        end
    endtask

    task automatic wait_out_frame();
        @(negedge clk_sys);
        while (!out_frame) @(negedge clk_sys);
    endtask

    // outputs quiet from reset until the first pulse
    task automatic check_reset_quiet();
        int n;
        n = 0;
        @(negedge clk_sys);
        while (!out_frame && n < FRAME_CYC) begin
            check_value("out_de", out_de, 0);
            @(negedge clk_sys);
            n++;
        end
        check_value("out_frame", out_frame, 1);
        check_value("out_sx", out_sx, 0);
        check_value("out_sy", out_sy, 0);
    endtask

    // one whole frame plus the next pulse on falling edges
    task automatic check_frame(input int img);
        int               x;
        int               y;
        logic             vis;
        logic             paint;
        logic [CIDXW-1:0] idx;
        logic [OUTW-1:0]  exp_c;
        wait_out_frame();
        for (int n = 0; n <= FRAME_CYC; n++) begin
            x     = n % H_TOTAL;
            y     = (n / H_TOTAL) % V_TOTAL;
            vis   = (x < H_ACTIVE) && (y < V_ACTIVE);
            paint = vis && (x < FB_W * FB_S) && (y < FB_H * FB_S);
            idx   = paint ? img_data[img][y / FB_S][x / FB_S] : '0;
            exp_c = paint ? {(OUTW / CIDXW){idx}} : '0;  // nibble repeated
            check_value("out_sx", out_sx, x);
            check_value("out_sy", out_sy, y);
            check_value("out_de", out_de, vis);
            check_value("out_frame", out_frame, (n % FRAME_CYC) == 0);
            check_value("out_r", out_r, exp_c);
            check_value("out_g", out_g, exp_c);
            check_value("out_b", out_b, exp_c);
            if (n < FRAME_CYC) begin
                @(negedge clk_sys);
            end
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        abort_run("timeout: the run took longer than six frames plus the writes");
    end

    initial begin
        void'($urandom(32'h36c9));
        rst_n  = 1'b0;
        fb_we  = 1'b0;
        fb_x   = '0;
        fb_y   = '0;
        fb_idx = '0;
        load_images();
        repeat (2) @(posedge clk_sys);
        rst_n <= 1'b1;
        check_reset_quiet();
        write_image(0, 1'b0);
        check_frame(0);
        write_image(1, 1'b1);
        write_pixel(FB_W, 4, 4'h0);  // x out of range would alias row 5 column 0
        check_frame(1);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
